// File: Bender.yml
package:
  name: halfband_interp

export_include_dirs:
  - .

sources:
  - hb_pkg.sv
  - rate_control.sv
  - zero_stuffer.sv
  - halfband_fir.sv
  - interp_gain.sv
  - halfband_interp_top.sv
  - target: test
    files:
      - halfband_interp_props.sv
      - tb_halfband_interp.sv

// File: files.f
+incdir+.
hb_pkg.sv
rate_control.sv
zero_stuffer.sv
halfband_fir.sv
interp_gain.sv
halfband_interp_top.sv
halfband_interp_props.sv
tb_halfband_interp.sv

// File: halfband_fir.sv
`include "hb_settings.svh"

// 7-tap symmetric halfband filter, pipelined on clk2_en.  Taps are folded
// before the multipliers and the products are added in a small tree.
module halfband_fir (
    input  logic                sys_clk,
    input  logic                reset,
    input  hb_pkg::hb_strobes_t strobes,
    input  hb_pkg::sample_t     x_in,
    output hb_pkg::sample_t     y
);

    import hb_pkg::*;

    localparam int TAPS   = 7;
    localparam int FOLDED = 4;      // three mirrored pairs and the centre.
    localparam int SUMLV2 = 2;
    localparam int PROD_W = 2 * `HB_WIDTH;

    // 0s18 coefficients, outer tap first.
    localparam sample_t COEF [FOLDED] = '{
        sample_t'(`HB_COEF0),
        sample_t'(`HB_COEF1),
        sample_t'(`HB_COEF2),
        sample_t'(`HB_COEF3)
    };

    sample_t                  x [TAPS];           // tap line, 2s16.
    sample_t                  sum_lvl_1 [FOLDED];
    logic signed [PROD_W-1:0] mult_out [FOLDED];  // 2s34.
    sample_t                  sum_lvl_2 [SUMLV2]; // 1s17.
    sample_t                  sum_lvl_3;

    // ************************************************************
    // tap line
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            x <= '{default: '0};
        end else if (strobes.clk2_en) begin
            // halve into 2s16 so the folded sums cannot overflow.
            x[0] <= {x_in[`HB_WIDTH-1], x_in[`HB_WIDTH-1:1]};
            for (int i = 1; i < TAPS; i++) begin
                x[i] <= x[i-1];
            end
        end
    end

    // ************************************************************
    // fold the symmetric taps
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            sum_lvl_1 <= '{default: '0};
        end else if (strobes.clk2_en) begin
            for (int i = 0; i < FOLDED - 1; i++) begin
                sum_lvl_1[i] <= x[i] + x[TAPS-1-i];
            end
            sum_lvl_1[FOLDED-1] <= x[FOLDED-1];     // centre tap alone.
        end
    end

    // 0s18 times 2s16 gives 2s34.
    always_comb begin
        for (int i = 0; i < FOLDED; i++) begin
            mult_out[i] = COEF[i] * sum_lvl_1[i];
        end
    end

    // ************************************************************
    // adder tree and output
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            sum_lvl_2 <= '{default: '0};
        end else if (strobes.clk2_en) begin
            for (int i = 0; i < SUMLV2; i++) begin
                // keep bits 34 down to 17 of each product.
                sum_lvl_2[i] <= $signed(mult_out[2*i][PROD_W-2:`HB_WIDTH-1])
                              + $signed(mult_out[2*i+1][PROD_W-2:`HB_WIDTH-1]);
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            sum_lvl_3 <= '0;
            y         <= '0;
        end else if (strobes.clk2_en) begin
            sum_lvl_3 <= sum_lvl_2[0] + sum_lvl_2[1];   // wraps at 18 bits.
            y         <= sum_lvl_3;
        end
    end

endmodule

// File: halfband_interp_props.sv
`include "hb_settings.svh"

module halfband_interp_props (
    input logic                        sys_clk,
    input logic                        reset,
    input hb_pkg::hb_strobes_t         strobes,
    input logic                        sample_req,
    input logic                        out_strobe,
    input logic                        clip,
    input logic signed [`HB_WIDTH-1:0] y
);

    localparam logic signed [`HB_WIDTH-1:0] RAIL_POS = {1'b0, {(`HB_WIDTH-1){1'b1}}};
    localparam logic signed [`HB_WIDTH-1:0] RAIL_NEG = {1'b1, {(`HB_WIDTH-1){1'b0}}};

    int unsigned fail_count = 0;

    // ************************************************************
    // strobes are single-cycle pulses
    // ************************************************************
    clk2_pulse: assert property (@(posedge sys_clk) disable iff (reset)
        strobes.clk2_en |=> !strobes.clk2_en)
        else begin
            fail_count++;
            $error("clk2_en wider than one cycle");
        end
    req_pulse: assert property (@(posedge sys_clk) disable iff (reset)
        sample_req |=> !sample_req)
        else begin
            fail_count++;
            $error("sample_req wider than one cycle");
        end
    out_pulse: assert property (@(posedge sys_clk) disable iff (reset)
        out_strobe |=> !out_strobe)
        else begin
            fail_count++;
            $error("out_strobe wider than one cycle");
        end

    sam_in_clk2: assert property (@(posedge sys_clk) disable iff (reset)
        strobes.sam_clk_en |-> strobes.clk2_en)
        else begin
            fail_count++;
            $error("sam_clk_en without clk2_en");
        end

    clip_at_rail: assert property (@(posedge sys_clk) disable iff (reset)
        clip |-> (y == RAIL_POS || y == RAIL_NEG))
        else begin
            fail_count++;
            $error("clip set off the rails");
        end

endmodule

bind halfband_interp_top halfband_interp_props u_props (
    .sys_clk    (sys_clk),
    .reset      (reset),
    .strobes    (strobes),
    .sample_req (sample_req),
    .out_strobe (out_strobe),
    .clip       (clip),
    .y          (y)
);

// File: halfband_interp_top.sv
`include "hb_settings.svh"

// Two-times halfband interpolator for one real sample stream.
module halfband_interp_top (
    input  logic                        sys_clk,
    input  logic                        reset,
    input  logic signed [`HB_WIDTH-1:0] x_in,
    output logic                        sample_req,
    output logic signed [`HB_WIDTH-1:0] y,
    output logic                        out_strobe,
    output logic                        clip
);

    import hb_pkg::*;

    hb_strobes_t strobes;
    sample_t     stuffed;
    sample_t     fir_out;
    hb_out_t     out_word;

    // ************************************************************
    // timing and datapath
    // ************************************************************
    rate_control u_rate_control (
        .sys_clk (sys_clk),
        .reset   (reset),
        .strobes (strobes)
    );

    zero_stuffer u_zero_stuffer (
        .sys_clk (sys_clk),
        .reset   (reset),
        .strobes (strobes),
        .x_in    (x_in),
        .stuffed (stuffed)
    );

    halfband_fir u_halfband_fir (
        .sys_clk (sys_clk),
        .reset   (reset),
        .strobes (strobes),
        .x_in    (stuffed),
        .y       (fir_out)
    );

    interp_gain u_interp_gain (
        .sys_clk (sys_clk),
        .reset   (reset),
        .strobes (strobes),
        .fir_out (fir_out),
        .out     (out_word)
    );

    assign sample_req = strobes.sam_clk_en;   // x_in is taken in this cycle.
    assign y          = out_word.sample;
    assign out_strobe = out_word.strobe;
    assign clip       = out_word.clip;

endmodule

// File: hb_pkg.sv
`include "hb_settings.svh"

package hb_pkg;

    // one real sample on the datapath.
    typedef logic signed [`HB_WIDTH-1:0] sample_t;

    // ************************************************************
    // timing strobes from the rate control block
    // ************************************************************
    typedef struct packed {
        logic clk2_en;      // high-rate tick, one sys_clk cycle wide.
        logic sam_clk_en;   // input-rate tick, only with clk2_en.
    } hb_strobes_t;

    // ************************************************************
    // output word of the interpolator
    // ************************************************************
    typedef struct packed {
        sample_t sample;    // gained, saturated filter output.
        logic    strobe;    // marks a new output word.
        logic    clip;      // sample was forced to a rail.
    } hb_out_t;

endpackage

// File: hb_settings.svh
`ifndef HB_SETTINGS_SVH
`define HB_SETTINGS_SVH

// sample word width, 2s16 after input halving inside the filter.
`define HB_WIDTH 18

// sys_clk cycles per high-rate tick, must be 2 or more.
`define HB_CLK2_DIV 4

// folded halfband coefficients in 0s18.
`define HB_COEF0 (-4244)
`define HB_COEF1 (0)
`define HB_COEF2 (36976)
`define HB_COEF3 (65472)

// high-rate ticks from the stuffed sequence to the matching output strobe.
`define HB_LATENCY 6

`endif

// File: interp_gain.sv
`include "hb_settings.svh"

// Doubles the filter output to make up for zero-stuffing and the input
// halving, saturating at the rails and flagging each clipped sample.
module interp_gain (
    input  logic                sys_clk,
    input  logic                reset,
    input  hb_pkg::hb_strobes_t strobes,
    input  hb_pkg::sample_t     fir_out,
    output hb_pkg::hb_out_t     out
);

    import hb_pkg::*;

    localparam sample_t RAIL_POS = {1'b0, {(`HB_WIDTH-1){1'b1}}};
    localparam sample_t RAIL_NEG = {1'b1, {(`HB_WIDTH-1){1'b0}}};

    logic    overflow;
    sample_t gained;

    // doubling leaves the range when the top two bits differ.
    assign overflow = fir_out[`HB_WIDTH-1] ^ fir_out[`HB_WIDTH-2];

    always_comb begin
        if (!overflow) begin
            gained = {fir_out[`HB_WIDTH-2:0], 1'b0};
        end else if (fir_out[`HB_WIDTH-1]) begin
            gained = RAIL_NEG;
        end else begin
            gained = RAIL_POS;
        end
    end

    // ************************************************************
    // output register
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            out <= '0;
        end else begin
            out.strobe <= strobes.clk2_en;      // cycle after the tick.
            if (strobes.clk2_en) begin
                out.sample <= gained;
                out.clip   <= overflow;
            end
        end
    end

endmodule

// File: rate_control.sv
`include "hb_settings.svh"

// Divides sys_clk into the two strobes the datapath runs on.  All timing in
// the interpolator comes from here.
module rate_control (
    input  logic                sys_clk,
    input  logic                reset,
    output hb_pkg::hb_strobes_t strobes
);

    localparam int CNT_W = (`HB_CLK2_DIV > 2) ? $clog2(`HB_CLK2_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`HB_CLK2_DIV - 1);

    logic [CNT_W-1:0] div_cnt;
    logic             phase;    // low on the input-rate tick.
    logic             wrap;

    assign wrap = (div_cnt == CNT_LAST);

    // ************************************************************
    // divide counter
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            div_cnt <= '0;
        end else if (wrap) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ************************************************************
    // strobes and phase
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            phase   <= 1'b0;
            strobes <= '0;
        end else begin
            strobes.clk2_en    <= wrap;
            strobes.sam_clk_en <= wrap & ~phase;   // every second tick.
            if (wrap) begin
                phase <= ~phase;
            end
        end
    end

endmodule

// File: tb_halfband_interp.sv
`include "hb_settings.svh"

module tb_halfband_interp;

    import hb_pkg::*;

    localparam int          DRIVE_DELAY  = 2;
    localparam int unsigned SEED         = 32'h98d60082;
    localparam int          RAIL_POS     = (1 << (`HB_WIDTH - 1)) - 1;
    localparam int          RAIL_NEG     = -(1 << (`HB_WIDTH - 1));
    localparam int          COEF_TAB [4] = '{`HB_COEF0, `HB_COEF1, `HB_COEF2, `HB_COEF3};
    localparam int          N_RANDOM     = 420;

    logic    sys_clk = 1'b0;
    logic    reset;
    sample_t x_in;
    logic    sample_req;
    sample_t y;
    logic    out_strobe;
    logic    clip;

    int stim_q[$];          // input samples still to present.
    int stuffed_hist[$];    // model of the zero-stuffed stream.
    int exp_y_q[$];
    bit exp_clip_q[$];
    int seen_y[$];
    int errors    = 0;
    int cycle     = 0;
    int last_req  = -1;
    int last_out  = -1;
    bit load_next = 1'b0;

    halfband_interp_top uut (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .x_in       (x_in),
        .sample_req (sample_req),
        .y          (y),
        .out_strobe (out_strobe),
        .clip       (clip)
    );

    always #20 sys_clk = ~sys_clk;  // period 40.

    task automatic check_value(input logic signed [63:0] actual,
                               input logic signed [63:0] expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at time %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("error at time %0t: %s", $time, why);
        $display("Regression failed");
        $fatal(1, "%s", why);
    endtask

    // ************************************************************
    // reference model
    // ************************************************************
    function automatic int wrap18(input longint value);
        sample_t t;
        t = sample_t'(value);
        return int'(t);
    endfunction

    // one stuffed word in, one expected output word out.
    function automatic void model_push(input int value);
        int     xs [7];
        int     s1 [4];
        int     p [4];
        int     s3;
        longint doubled;
        stuffed_hist.push_back(value);
        for (int i = 0; i < 7; i++) begin
            xs[i] = (stuffed_hist.size() > i) ? (stuffed_hist[$-i] >>> 1) : 0;  // halved.
        end
        for (int i = 0; i < 3; i++) begin
            s1[i] = wrap18(xs[i] + xs[6-i]);
        end
        s1[3] = xs[3];
        for (int i = 0; i < 4; i++) begin
            p[i] = wrap18((longint'(COEF_TAB[i]) * s1[i]) >>> 17);  // bits 34..17.
        end
        s3 = wrap18(wrap18(p[0] + p[1]) + wrap18(p[2] + p[3]));
        doubled = 2 * longint'(s3);
        exp_clip_q.push_back(doubled > RAIL_POS || doubled < RAIL_NEG);
        if (doubled > RAIL_POS) begin
            exp_y_q.push_back(RAIL_POS);
        end else if (doubled < RAIL_NEG) begin
            exp_y_q.push_back(RAIL_NEG);
        end else begin
            exp_y_q.push_back(int'(doubled));
        end
    endfunction

    function automatic int next_stim();
        if (stim_q.size() == 0) begin
            return 0;   // stream runs out into zeros.
        end
        return stim_q.pop_front();
    endfunction

    // ************************************************************
    // per-cycle driver and monitor
    // ************************************************************
    task automatic step();
        @(posedge sys_clk);
        #DRIVE_DELAY;
        cycle++;
        if (uut.u_props.fail_count != 0) begin
            abort_run("a bound assertion on the DUT failed");
        end
        if (load_next) begin
            x_in = sample_t'(next_stim());
            load_next = 1'b0;
        end
        if (sample_req) begin
            if (last_req >= 0) begin
                check_value(cycle - last_req, 2 * `HB_CLK2_DIV, "sample_req spacing");
            end
            last_req = cycle;
            model_push(x_in);   // x_in is taken at the coming edge.
            model_push(0);
            load_next = 1'b1;
        end
        if (out_strobe) begin
            if (last_out >= 0) begin
                check_value(cycle - last_out, `HB_CLK2_DIV, "out_strobe spacing");
            end
            last_out = cycle;
            if (exp_y_q.size() == 0) begin
                abort_run("an output strobe came with no expected sample left");
            end else begin
                check_value(y, exp_y_q.pop_front(), "y");
                check_value(clip, exp_clip_q.pop_front(), "clip");
                seen_y.push_back(y);
            end
        end
    endtask

    task automatic run_until_outputs(input int target);
        int waited;
        int limit;
        waited = 0;
        limit  = (target - seen_y.size() + 4) * 2 * `HB_CLK2_DIV;
        while (seen_y.size() < target) begin
            step();
            waited++;
            if (waited > limit) begin
                abort_run($sformatf("timed out waiting for output %0d", target));
            end
        end
    endtask

    initial begin
        int waited;
        int n_stim;
        int tap;
        int fold;
        int imp;
        reset = 1'b1;
        x_in  = '0;
        void'($urandom(SEED));
        for (int i = 0; i < `HB_LATENCY; i++) begin
            exp_y_q.push_back(0);   // pipeline starts from zero.
            exp_clip_q.push_back(1'b0);
        end
        stim_q.push_back(65536);    // impulse.
        repeat (15) stim_q.push_back(0);
        for (int i = 0; i < N_RANDOM; i++) begin
            stim_q.push_back((i % 16 == 7) ? RAIL_NEG : wrap18(longint'($urandom())));
        end
        // full scale both ways; the folded taps keep the doubled sum inside the rails.
        repeat (12) stim_q.push_back(RAIL_POS);
        repeat (12) stim_q.push_back(RAIL_NEG);
        repeat (8) stim_q.push_back(0);
        n_stim = stim_q.size();

        repeat (8) @(posedge sys_clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        x_in  = sample_t'(next_stim());

        waited = 0;
        do begin
            check_value(y, 0, "y after reset");
            check_value(out_strobe, 0, "out_strobe after reset");
            check_value(clip, 0, "clip after reset");
            step();
            waited++;
            if (waited > 4 * `HB_CLK2_DIV) begin
                abort_run("sample_req never came after reset");
            end
        end while (!sample_req);
        check_value(waited, `HB_CLK2_DIV, "cycles from reset release to sample_req");

        // impulse response straight from the folded coefficients.
        run_until_outputs(30);
        for (int i = 0; i < 30; i++) begin
            tap = i - `HB_LATENCY;
            imp = 0;
            if (tap >= 0 && tap < 7) begin
                fold = (tap <= 3) ? tap : 6 - tap;
                imp  = 2 * int'((longint'(COEF_TAB[fold]) * (65536 / 2)) >>> 17);
            end
            check_value(seen_y[i], imp, $sformatf("impulse response output %0d", i));
        end

        run_until_outputs(`HB_LATENCY + 2 * n_stim);

        if (errors == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: zero_stuffer.sv
// Turns the input-rate stream into a high-rate stream by putting a sample on
// one clk2_en tick and a zero on the next.
module zero_stuffer (
    input  logic                sys_clk,
    input  logic                reset,
    input  hb_pkg::hb_strobes_t strobes,
    input  hb_pkg::sample_t     x_in,
    output hb_pkg::sample_t     stuffed
);

    logic take_sample;

    // x_in is valid in the same cycle as sam_clk_en.
    assign take_sample = strobes.clk2_en & strobes.sam_clk_en;

    // ************************************************************
    // stuffing register
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            stuffed <= '0;
        end else if (take_sample) begin
            stuffed <= x_in;
        end else if (strobes.clk2_en) begin
            stuffed <= '0;                  // the inserted zero.
        end
    end

    // the word holds between ticks so the filter sees it stable.

endmodule
